// File: hw/rv_decode_pkg.sv
// shared RV64 decode widths and encodings; enum values are internal to the pipeline and not ISA fields
package rv_decode_pkg;

  localparam int XLEN        = 64;
  localparam int INST_WD     = 32;
  localparam int GPR_ADDR_WD = 5;

  typedef logic [GPR_ADDR_WD-1:0] gpr_addr_t;
  typedef logic [XLEN-1:0]        xdata_t;
  typedef logic [INST_WD-1:0]     inst_t;

  // major opcodes of the decoded subset
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_LOAD      = 7'b0000011;
  localparam logic [6:0] OPC_STORE     = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;

  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_LUI_PASS   // operand 2 straight through
  } alu_op_t;

  typedef enum logic {SRC1_RS1, SRC1_PC} src1_sel_t;

  typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} src2_sel_t;

  typedef logic [2:0] mem_op_t;    // load/store funct3
  typedef logic [2:0] br_func_t;   // branch funct3

  localparam br_func_t BR_BEQ  = 3'b000;
  localparam br_func_t BR_BNE  = 3'b001;
  localparam br_func_t BR_BLT  = 3'b100;
  localparam br_func_t BR_BGE  = 3'b101;
  localparam br_func_t BR_BLTU = 3'b110;
  localparam br_func_t BR_BGEU = 3'b111;

endpackage

// File: hw/ds_pipe_ctrl.sv
// one-entry decode stage register; hazard check uses raw rs fields, so unused fields may hold
`timescale 1ns/1ns

module ds_pipe_ctrl (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_fs_to_ds_valid,
  input  rv_decode_pkg::inst_t      i_fs_inst,
  input  rv_decode_pkg::xdata_t     i_fs_pc,
  input  logic                      i_es_allowin,
  input  logic                      i_br_stall,
  input  rv_decode_pkg::gpr_addr_t  i_rs1,
  input  rv_decode_pkg::gpr_addr_t  i_rs2,
  input  rv_decode_pkg::gpr_addr_t  i_es_rd,
  input  rv_decode_pkg::gpr_addr_t  i_ms_rd,
  input  rv_decode_pkg::gpr_addr_t  i_ws_rd,
  output logic                      o_ds_allowin,
  output logic                      o_ds_to_es_valid,
  output logic                      o_ds_go,
  output rv_decode_pkg::inst_t      o_ds_inst,
  output rv_decode_pkg::xdata_t     o_ds_pc
);

  logic ds_valid;
  logic ds_ready_go;
  logic raw_hazard;

  // x0 never carries a pending write
  function automatic logic rd_hit(input rv_decode_pkg::gpr_addr_t rd,
                                  input rv_decode_pkg::gpr_addr_t rs1,
                                  input rv_decode_pkg::gpr_addr_t rs2);
    return (rd != '0) && (rd == rs1 || rd == rs2);
  endfunction

  assign raw_hazard = rd_hit(i_es_rd, i_rs1, i_rs2) ||
                      rd_hit(i_ms_rd, i_rs1, i_rs2) ||
                      rd_hit(i_ws_rd, i_rs1, i_rs2);

  assign ds_ready_go      = !raw_hazard;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;
  assign o_ds_go          = o_ds_to_es_valid && i_es_allowin;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid && !i_br_stall;  // wrong-path fetch dropped
    end
  end

  // payload only moves with an accepted fetch
  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      o_ds_inst <= i_fs_inst;
      o_ds_pc   <= i_fs_pc;
    end
  end

endmodule

// File: hw/inst_decoder.sv
// RV64I subset only; M, A, FENCE and SYSTEM encodings all decode as invalid
`timescale 1ns/1ns

module inst_decoder (
  input  rv_decode_pkg::inst_t      i_inst,
  output rv_decode_pkg::gpr_addr_t  o_rs1,
  output rv_decode_pkg::gpr_addr_t  o_rs2,
  output rv_decode_pkg::gpr_addr_t  o_rd,
  output rv_decode_pkg::xdata_t     o_imm,
  output rv_decode_pkg::alu_op_t    o_alu_op,
  output rv_decode_pkg::src1_sel_t  o_src1_sel,
  output rv_decode_pkg::src2_sel_t  o_src2_sel,
  output logic                      o_word_op,
  output logic                      o_gpr_wen,
  output logic                      o_mem_ren,
  output logic                      o_mem_wen,
  output rv_decode_pkg::mem_op_t    o_mem_op,
  output logic                      o_bren,
  output logic                      o_jal,
  output logic                      o_jalr,
  output rv_decode_pkg::br_func_t   o_br_func,
  output logic                      o_invalid
);

  localparam int XL = rv_decode_pkg::XLEN;

  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  rv_decode_pkg::xdata_t  imm_i;
  rv_decode_pkg::xdata_t  imm_s;
  rv_decode_pkg::xdata_t  imm_b;
  rv_decode_pkg::xdata_t  imm_u;
  rv_decode_pkg::xdata_t  imm_j;
  rv_decode_pkg::alu_op_t arith_op;
  logic                   f7_ok;
  logic                   shift_ok;
  logic                   invalid;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{(XL-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XL-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XL-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(XL-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XL-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  // base op, or the alternate sub/sra form
  assign f7_ok    = (funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
  // rv64 shamt is 6 bits wide
  assign shift_ok = (i_inst[31:26] == 6'b000000) ||
                    (i_inst[31:26] == 6'b010000 && funct3 == 3'b101);

  always_comb begin
    case (funct3)
      3'b000:  arith_op = funct7[5] ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
      3'b001:  arith_op = rv_decode_pkg::ALU_SLL;
      3'b010:  arith_op = rv_decode_pkg::ALU_SLT;
      3'b011:  arith_op = rv_decode_pkg::ALU_SLTU;
      3'b100:  arith_op = rv_decode_pkg::ALU_XOR;
      3'b101:  arith_op = funct7[5] ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
      3'b110:  arith_op = rv_decode_pkg::ALU_OR;
      default: arith_op = rv_decode_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    o_imm      = imm_i;
    o_alu_op   = rv_decode_pkg::ALU_ADD;
    o_src1_sel = rv_decode_pkg::SRC1_RS1;
    o_src2_sel = rv_decode_pkg::SRC2_IMM;
    o_word_op  = 1'b0;
    o_gpr_wen  = 1'b0;
    o_mem_ren  = 1'b0;
    o_mem_wen  = 1'b0;
    o_bren     = 1'b0;
    o_jal      = 1'b0;
    o_jalr     = 1'b0;
    invalid    = 1'b0;
    case (opcode)
      rv_decode_pkg::OPC_LUI: begin
        o_imm     = imm_u;
        o_alu_op  = rv_decode_pkg::ALU_LUI_PASS;
        o_gpr_wen = 1'b1;
      end
      rv_decode_pkg::OPC_AUIPC: begin
        o_imm      = imm_u;
        o_src1_sel = rv_decode_pkg::SRC1_PC;
        o_gpr_wen  = 1'b1;
      end
      rv_decode_pkg::OPC_JAL, rv_decode_pkg::OPC_JALR: begin
        o_imm      = (opcode == rv_decode_pkg::OPC_JAL) ? imm_j : imm_i;
        o_src1_sel = rv_decode_pkg::SRC1_PC;     // link = pc + 4
        o_src2_sel = rv_decode_pkg::SRC2_FOUR;
        o_gpr_wen  = 1'b1;
        o_jal      = (opcode == rv_decode_pkg::OPC_JAL);
        o_jalr     = (opcode == rv_decode_pkg::OPC_JALR);
        invalid    = o_jalr && (funct3 != 3'b000);
      end
      rv_decode_pkg::OPC_BRANCH: begin
        o_imm   = imm_b;
        o_bren  = 1'b1;
        invalid = (funct3 == 3'b010 || funct3 == 3'b011);
      end
      rv_decode_pkg::OPC_LOAD: begin
        o_mem_ren = 1'b1;
        o_gpr_wen = 1'b1;
        invalid   = (funct3 == 3'b111);
      end
      rv_decode_pkg::OPC_STORE: begin
        o_imm     = imm_s;
        o_mem_wen = 1'b1;
        invalid   = funct3[2];
      end
      rv_decode_pkg::OPC_OP_IMM: begin
        o_gpr_wen = 1'b1;
        if (funct3 != 3'b000) begin
          o_alu_op = arith_op;   // addi ignores bit 30
        end
        invalid = (funct3 == 3'b001 || funct3 == 3'b101) && !shift_ok;
      end
      rv_decode_pkg::OPC_OP_IMM_32: begin
        o_word_op = 1'b1;
        o_gpr_wen = 1'b1;
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
          o_alu_op = arith_op;
          invalid  = !f7_ok;
        end else if (funct3 != 3'b000) begin
          invalid = 1'b1;
        end
      end
      rv_decode_pkg::OPC_OP, rv_decode_pkg::OPC_OP_32: begin
        o_alu_op   = arith_op;
        o_src2_sel = rv_decode_pkg::SRC2_RS2;
        o_gpr_wen  = 1'b1;
        o_word_op  = (opcode == rv_decode_pkg::OPC_OP_32);
        invalid    = !f7_ok ||
                     (o_word_op && !(funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101));
      end
      default: invalid = 1'b1;
    endcase
    // nothing side-effecting leaves an invalid instruction
    if (invalid) begin
      o_gpr_wen = 1'b0;
      o_mem_ren = 1'b0;
      o_mem_wen = 1'b0;
      o_bren    = 1'b0;
      o_jal     = 1'b0;
      o_jalr    = 1'b0;
    end
  end

  assign o_rs1     = i_inst[19:15];
  assign o_rs2     = i_inst[24:20];
  assign o_rd      = o_gpr_wen ? i_inst[11:7] : '0;  // zero for branch and store
  assign o_mem_op  = funct3;
  assign o_br_func = funct3;
  assign o_invalid = invalid;

endmodule

// File: hw/gpr_file.sv
// 31 stored entries, x0 hardwired; write and read of one register in a cycle return the old value
`timescale 1ns/1ns

module gpr_file #(
  parameter bit GPR_RESET_ZERO = 1'b0
) (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  rv_decode_pkg::gpr_addr_t  i_raddr1,
  input  rv_decode_pkg::gpr_addr_t  i_raddr2,
  input  logic                      i_wen,
  input  rv_decode_pkg::gpr_addr_t  i_waddr,
  input  rv_decode_pkg::xdata_t     i_wdata,
  output rv_decode_pkg::xdata_t     o_rdata1,
  output rv_decode_pkg::xdata_t     o_rdata2
);

  localparam int NREGS = 1 << rv_decode_pkg::GPR_ADDR_WD;

  rv_decode_pkg::xdata_t regs [1:NREGS-1];

  always_ff @(posedge i_clk) begin
    if (GPR_RESET_ZERO && !i_rst_n) begin
      for (int i = 1; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_waddr != '0) begin  // x0 writes dropped
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// File: hw/branch_unit.sv
// redirect outputs mean something only while i_go is high; target is not checked for alignment
`timescale 1ns/1ns

module branch_unit (
  input  logic                     i_go,
  input  rv_decode_pkg::xdata_t    i_pc,
  input  rv_decode_pkg::xdata_t    i_fs_pc,
  input  rv_decode_pkg::xdata_t    i_rs1_data,
  input  rv_decode_pkg::xdata_t    i_rs2_data,
  input  rv_decode_pkg::xdata_t    i_imm,
  input  logic                     i_bren,
  input  logic                     i_jal,
  input  logic                     i_jalr,
  input  rv_decode_pkg::br_func_t  i_br_func,
  output logic                     o_br_taken,
  output rv_decode_pkg::xdata_t    o_br_target,
  output logic                     o_br_stall
);

  logic                  eq;
  logic                  lt;
  logic                  ltu;
  logic                  cond;
  rv_decode_pkg::xdata_t jalr_sum;

  assign eq  = (i_rs1_data == i_rs2_data);
  assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_br_func)
      rv_decode_pkg::BR_BEQ:  cond = eq;
      rv_decode_pkg::BR_BNE:  cond = !eq;
      rv_decode_pkg::BR_BLT:  cond = lt;
      rv_decode_pkg::BR_BGE:  cond = !lt;
      rv_decode_pkg::BR_BLTU: cond = ltu;
      rv_decode_pkg::BR_BGEU: cond = !ltu;
      default:                cond = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1_data + i_imm;

  assign o_br_target = i_jalr ? {jalr_sum[rv_decode_pkg::XLEN-1:1], 1'b0} : i_pc + i_imm;
  assign o_br_taken  = i_go && (i_jal || i_jalr || (i_bren && cond));
  // fetch already on the right path needs no flush
  assign o_br_stall  = o_br_taken && (o_br_target != i_fs_pc);

endmodule

// File: hw/id_stage.sv
// RV64 decode stage without CSR, trap or debug support; operands and controls valid with o_ds_to_es_valid
`timescale 1ns/1ns

module id_stage #(
  parameter bit GPR_RESET_ZERO = 1'b0
) (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_fs_to_ds_valid,
  input  rv_decode_pkg::inst_t      i_fs_inst,
  input  rv_decode_pkg::xdata_t     i_fs_pc,
  input  logic                      i_es_allowin,
  input  rv_decode_pkg::gpr_addr_t  i_es_rd,
  input  rv_decode_pkg::gpr_addr_t  i_ms_rd,
  input  rv_decode_pkg::gpr_addr_t  i_ws_rd,
  input  logic                      i_rf_wen,
  input  rv_decode_pkg::gpr_addr_t  i_rf_waddr,
  input  rv_decode_pkg::xdata_t     i_rf_wdata,
  output logic                      o_ds_allowin,
  output logic                      o_ds_to_es_valid,
  output rv_decode_pkg::xdata_t     o_rs1_data,
  output rv_decode_pkg::xdata_t     o_rs2_data,
  output rv_decode_pkg::xdata_t     o_imm,
  output rv_decode_pkg::xdata_t     o_pc,
  output rv_decode_pkg::alu_op_t    o_alu_op,
  output rv_decode_pkg::src1_sel_t  o_src1_sel,
  output rv_decode_pkg::src2_sel_t  o_src2_sel,
  output logic                      o_word_op,
  output rv_decode_pkg::gpr_addr_t  o_rd,
  output logic                      o_gpr_wen,
  output logic                      o_mem_ren,
  output logic                      o_mem_wen,
  output rv_decode_pkg::mem_op_t    o_mem_op,
  output logic                      o_invalid,
  output logic                      o_br_taken,
  output rv_decode_pkg::xdata_t     o_br_target,
  output logic                      o_br_stall
);

  logic                      ds_go;
  rv_decode_pkg::inst_t      ds_inst;
  rv_decode_pkg::gpr_addr_t  rs1;
  rv_decode_pkg::gpr_addr_t  rs2;
  logic                      bren;
  logic                      jal;
  logic                      jalr;
  rv_decode_pkg::br_func_t   br_func;

  ds_pipe_ctrl u_ctrl (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_es_allowin     (i_es_allowin),
    .i_br_stall       (o_br_stall),
    .i_rs1            (rs1),
    .i_rs2            (rs2),
    .i_es_rd          (i_es_rd),
    .i_ms_rd          (i_ms_rd),
    .i_ws_rd          (i_ws_rd),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_go          (ds_go),
    .o_ds_inst        (ds_inst),
    .o_ds_pc          (o_pc)
  );

  inst_decoder u_dec (
    .i_inst     (ds_inst),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (o_rd),
    .o_imm      (o_imm),
    .o_alu_op   (o_alu_op),
    .o_src1_sel (o_src1_sel),
    .o_src2_sel (o_src2_sel),
    .o_word_op  (o_word_op),
    .o_gpr_wen  (o_gpr_wen),
    .o_mem_ren  (o_mem_ren),
    .o_mem_wen  (o_mem_wen),
    .o_mem_op   (o_mem_op),
    .o_bren     (bren),
    .o_jal      (jal),
    .o_jalr     (jalr),
    .o_br_func  (br_func),
    .o_invalid  (o_invalid)
  );

  gpr_file #(
    .GPR_RESET_ZERO (GPR_RESET_ZERO)
  ) u_gpr (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wen    (i_rf_wen),
    .i_waddr  (i_rf_waddr),
    .i_wdata  (i_rf_wdata),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data)
  );

  branch_unit u_bru (
    .i_go        (ds_go),
    .i_pc        (o_pc),
    .i_fs_pc     (i_fs_pc),
    .i_rs1_data  (o_rs1_data),
    .i_rs2_data  (o_rs2_data),
    .i_imm       (o_imm),
    .i_bren      (bren),
    .i_jal       (jal),
    .i_jalr      (jalr),
    .i_br_func   (br_func),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target),
    .o_br_stall  (o_br_stall)
  );

endmodule

// File: testbench/id_stage_assertions.sv
// handshake and redirect properties, sampled on the rising clock outside reset
`timescale 1ns/1ns

module id_stage_assertions (
  input logic                      i_clk,
  input logic                      i_rst_n,
  input logic                      i_es_allowin,
  input logic                      o_ds_to_es_valid,
  input logic                      o_br_taken,
  input logic                      o_br_stall,
  input rv_decode_pkg::xdata_t     o_pc,
  input rv_decode_pkg::xdata_t     o_imm,
  input rv_decode_pkg::xdata_t     o_rs1_data,
  input rv_decode_pkg::xdata_t     o_rs2_data,
  input rv_decode_pkg::gpr_addr_t  o_rd
);

  // a flushed fetch never reaches execute
  stall_needs_taken: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_br_stall |=> ($past(o_br_taken) && !o_ds_to_es_valid))
    else $error("redirect stall without taken branch or without discard");

  taken_only_on_go: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_br_taken |-> (o_ds_to_es_valid && i_es_allowin)) else $error("redirect while held");

  // held instruction keeps its outputs
  hold_is_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_ds_to_es_valid && !i_es_allowin) |=>
      ($stable(o_pc) && $stable(o_imm) && $stable(o_rs1_data) && $stable(o_rs2_data) &&
       $stable(o_rd))) else $error("outputs changed under back-pressure");

endmodule

// File: testbench/tb_id_stage.sv
// directed tests of the decode stage; fetch, execute and writeback are modeled by the bench only
`timescale 1ns/1ns

module tb_id_stage;

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 16;
  localparam int NUM_TESTS  = 6;
  localparam logic [31:0] LFSR_SEED = 32'h497d;
  localparam rv_decode_pkg::inst_t NOP = 32'h00000013;  // addi x0, x0, 0

  logic                      i_clk;
  logic                      i_rst_n;
  logic                      i_fs_to_ds_valid;
  rv_decode_pkg::inst_t      i_fs_inst;
  rv_decode_pkg::xdata_t     i_fs_pc;
  logic                      i_es_allowin;
  rv_decode_pkg::gpr_addr_t  i_es_rd;
  rv_decode_pkg::gpr_addr_t  i_ms_rd;
  rv_decode_pkg::gpr_addr_t  i_ws_rd;
  logic                      i_rf_wen;
  rv_decode_pkg::gpr_addr_t  i_rf_waddr;
  rv_decode_pkg::xdata_t     i_rf_wdata;
  logic                      o_ds_allowin;
  logic                      o_ds_to_es_valid;
  rv_decode_pkg::xdata_t     o_rs1_data;
  rv_decode_pkg::xdata_t     o_rs2_data;
  rv_decode_pkg::xdata_t     o_imm;
  rv_decode_pkg::xdata_t     o_pc;
  rv_decode_pkg::alu_op_t    o_alu_op;
  rv_decode_pkg::src1_sel_t  o_src1_sel;
  rv_decode_pkg::src2_sel_t  o_src2_sel;
  logic                      o_word_op;
  rv_decode_pkg::gpr_addr_t  o_rd;
  logic                      o_gpr_wen;
  logic                      o_mem_ren;
  logic                      o_mem_wen;
  rv_decode_pkg::mem_op_t    o_mem_op;
  logic                      o_invalid;
  logic                      o_br_taken;
  rv_decode_pkg::xdata_t     o_br_target;
  logic                      o_br_stall;

  rv_decode_pkg::xdata_t model [32];  // expected register contents
  logic [31:0]           lfsr_state = LFSR_SEED;

  id_stage #(.GPR_RESET_ZERO(1'b1)) i_dut (.*);

  bind id_stage id_stage_assertions u_assert (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .i_es_allowin (i_es_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid), .o_br_taken (o_br_taken),
    .o_br_stall (o_br_stall), .o_pc (o_pc), .o_imm (o_imm),
    .o_rs1_data (o_rs1_data), .o_rs2_data (o_rs2_data), .o_rd (o_rd)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // 60 cycles per test on top of reset
  initial begin
    #((NUM_TESTS * 60 + RST_CYCLES) * CLK_PERIOD);
    $display("watchdog expired before the tests completed");
    $display("test failed");
    $fatal(1);
  end

  // galois form of x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic rv_decode_pkg::xdata_t rand_word();
    rv_decode_pkg::xdata_t w;
    w = '0;
    for (int i = 0; i < 64; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[62:0], lfsr_state[0]};
    end
    return w;
  endfunction

  function automatic rv_decode_pkg::xdata_t sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic rv_decode_pkg::inst_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic rv_decode_pkg::inst_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_decode_pkg::inst_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic rv_decode_pkg::inst_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic rv_decode_pkg::inst_t j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input rv_decode_pkg::xdata_t got,
                            input rv_decode_pkg::xdata_t exp);
    if (got !== exp)
      stop_on_error($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_alu(input string name, input rv_decode_pkg::alu_op_t got,
                           input rv_decode_pkg::alu_op_t exp);
    if (got !== exp)
      stop_on_error($sformatf("Error at %0t: %s is %s, expected %s", $time, name,
                              got.name(), exp.name()));
  endtask

  task automatic check_addr(input string name, input rv_decode_pkg::gpr_addr_t got,
                            input rv_decode_pkg::gpr_addr_t exp);
    if (got !== exp)
      stop_on_error($sformatf("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, exp));
  endtask

  task automatic tick();
    @(posedge i_clk);
    #1;
  endtask

  task automatic settle();
    #2;
  endtask

  task automatic write_reg(input rv_decode_pkg::gpr_addr_t addr, input rv_decode_pkg::xdata_t data);
    tick();
    i_rf_wen   = 1'b1;
    i_rf_waddr = addr;
    i_rf_wdata = data;
    tick();
    i_rf_wen = 1'b0;
    if (addr != 5'd0) model[addr] = data;
  endtask

  // present one fetch and hold it until the stage takes it
  task automatic issue(input rv_decode_pkg::inst_t inst, input rv_decode_pkg::xdata_t pc);
    int n;
    tick();
    i_fs_to_ds_valid = 1'b1;
    i_fs_inst        = inst;
    i_fs_pc          = pc;
    settle();
    n = 0;
    while (!o_ds_allowin) begin
      tick();
      settle();
      n++;
      if (n > 40) stop_on_error("stage never accepted the fetched instruction");
    end
    tick();
    i_fs_to_ds_valid = 1'b0;
  endtask

  task automatic wait_valid();
    int n;
    settle();
    n = 0;
    while (!o_ds_to_es_valid) begin
      tick();
      settle();
      n++;
      if (n > 40) stop_on_error("instruction never became valid toward execute");
    end
  endtask

  task automatic check_ctrl(input rv_decode_pkg::alu_op_t alu, input rv_decode_pkg::src1_sel_t s1,
      input rv_decode_pkg::src2_sel_t s2, input logic word, input rv_decode_pkg::gpr_addr_t rd,
      input logic gwen, input logic mren, input logic mwen);
    check_alu("o_alu_op", o_alu_op, alu);
    check_data("o_src1_sel", 64'(o_src1_sel), 64'(s1));
    check_data("o_src2_sel", 64'(o_src2_sel), 64'(s2));
    check_bit("o_word_op", o_word_op, word);
    check_addr("o_rd", o_rd, rd);
    check_bit("o_gpr_wen", o_gpr_wen, gwen);
    check_bit("o_mem_ren", o_mem_ren, mren);
    check_bit("o_mem_wen", o_mem_wen, mwen);
  endtask

  task automatic reset_values();
    settle();
    check_bit("o_ds_to_es_valid", o_ds_to_es_valid, 1'b0);
    check_bit("o_br_taken", o_br_taken, 1'b0);
    check_bit("o_br_stall", o_br_stall, 1'b0);
    check_bit("o_ds_allowin", o_ds_allowin, 1'b1);
  endtask

  task automatic decode_and_operands();
    rv_decode_pkg::xdata_t v;
    for (int r = 0; r < 32; r++) model[r] = '0;
    for (int r = 1; r < 8; r++) write_reg(5'(r), rand_word());
    v = rand_word();
    write_reg(5'd8, {1'b1, v[62:0]});                 // negative as signed
    write_reg(5'd10, {1'b0, v[63:1]});
    if (model[2] == model[1]) write_reg(5'd2, ~model[1]);
    write_reg(5'd0, rand_word());
    issue(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011), 64'h100);
    wait_valid();
    check_data("o_rs1_data", o_rs1_data, model[1]);
    check_data("o_rs2_data", o_rs2_data, model[2]);
    check_data("o_pc", o_pc, 64'h100);
    check_ctrl(rv_decode_pkg::ALU_ADD, rv_decode_pkg::SRC1_RS1, rv_decode_pkg::SRC2_RS2,
               1'b0, 5'd3, 1'b1, 1'b0, 1'b0);
    issue(i_type(12'hffd, 5'd5, 3'b000, 5'd4, 7'b0010011), 64'h104);
    wait_valid();
    check_data("o_rs1_data", o_rs1_data, model[5]);
    check_data("o_imm", o_imm, sext12(12'hffd));
    check_ctrl(rv_decode_pkg::ALU_ADD, rv_decode_pkg::SRC1_RS1, rv_decode_pkg::SRC2_IMM,
               1'b0, 5'd4, 1'b1, 1'b0, 1'b0);
    issue(i_type(12'h7ff, 5'd7, 3'b000, 5'd6, 7'b0011011), 64'h108);
    wait_valid();
    check_data("o_rs1_data", o_rs1_data, model[7]);
    check_data("o_imm", o_imm, 64'h7ff);
    check_ctrl(rv_decode_pkg::ALU_ADD, rv_decode_pkg::SRC1_RS1, rv_decode_pkg::SRC2_IMM,
               1'b1, 5'd6, 1'b1, 1'b0, 1'b0);
    issue(i_type(12'h923, 5'd1, 3'b010, 5'd7, 7'b0000011), 64'h10c);
    wait_valid();
    check_data("o_imm", o_imm, sext12(12'h923));
    check_data("o_mem_op", 64'(o_mem_op), 64'd2);
    check_ctrl(rv_decode_pkg::ALU_ADD, rv_decode_pkg::SRC1_RS1, rv_decode_pkg::SRC2_IMM,
               1'b0, 5'd7, 1'b1, 1'b1, 1'b0);
    issue(s_type(12'hff0, 5'd2, 5'd1, 3'b010), 64'h110);
    wait_valid();
    check_data("o_rs2_data", o_rs2_data, model[2]);
    check_data("o_imm", o_imm, sext12(12'hff0));
    check_data("o_mem_op", 64'(o_mem_op), 64'd2);
    check_ctrl(rv_decode_pkg::ALU_ADD, rv_decode_pkg::SRC1_RS1, rv_decode_pkg::SRC2_IMM,
               1'b0, 5'd0, 1'b0, 1'b0, 1'b1);
    issue({20'h80001, 5'd13, 7'b0110111}, 64'h114);
    wait_valid();
    check_data("o_imm", o_imm, 64'hffffffff80001000);
    check_ctrl(rv_decode_pkg::ALU_LUI_PASS, rv_decode_pkg::SRC1_RS1, rv_decode_pkg::SRC2_IMM,
               1'b0, 5'd13, 1'b1, 1'b0, 1'b0);
    issue(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd3, 7'b0110011), 64'h118);
    wait_valid();
    check_data("o_rs1_data x0", o_rs1_data, 64'd0);
    check_data("o_rs2_data x0", o_rs2_data, 64'd0);
  endtask

  task automatic hazard_interlock();
    issue(i_type(12'h001, 5'd0, 3'b000, 5'd4, 7'b0010011), 64'h200);  // rs1 is x0 so no hold
    settle();
    check_bit("o_ds_to_es_valid rs x0", o_ds_to_es_valid, 1'b1);
    tick();
    i_es_rd = 5'd2;
    issue(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011), 64'h204);
    for (int s = 0; s < 3; s++) begin
      settle();
      check_bit("o_ds_to_es_valid under hazard", o_ds_to_es_valid, 1'b0);
      check_bit("o_ds_allowin under hazard", o_ds_allowin, 1'b0);
      tick();
      i_es_rd = (s == 0) ? 5'd0 : i_es_rd;
      i_ms_rd = (s == 0) ? 5'd2 : 5'd0;
      i_ws_rd = (s == 1) ? 5'd2 : 5'd0;
    end
    wait_valid();
    check_data("o_rs2_data after hazard", o_rs2_data, model[2]);
  endtask

  task automatic backpressure_hold();
    tick();
    i_es_allowin = 1'b0;
    issue(i_type(12'h055, 5'd6, 3'b000, 5'd9, 7'b0010011), 64'h300);
    wait_valid();
    check_bit("o_ds_allowin stalled", o_ds_allowin, 1'b0);
    repeat (3) tick();
    settle();
    check_bit("o_ds_to_es_valid held", o_ds_to_es_valid, 1'b1);
    check_data("o_imm held", o_imm, 64'h55);
    check_data("o_rs1_data held", o_rs1_data, model[6]);
    check_addr("o_rd held", o_rd, 5'd9);
    check_data("o_pc held", o_pc, 64'h300);
    check_bit("o_ds_allowin stalled", o_ds_allowin, 1'b0);
    tick();
    i_es_allowin     = 1'b1;
    i_fs_to_ds_valid = 1'b1;
    i_fs_inst        = NOP;
    i_fs_pc          = 64'h304;
    settle();
    check_bit("o_ds_allowin released", o_ds_allowin, 1'b1);
    tick();
    i_fs_to_ds_valid = 1'b0;
    wait_valid();
    check_data("o_pc next", o_pc, 64'h304);
  endtask

  task automatic run_branch(input rv_decode_pkg::inst_t inst, input rv_decode_pkg::xdata_t pc,
      input rv_decode_pkg::xdata_t fs_pc, input logic exp_taken,
      input rv_decode_pkg::xdata_t exp_target);
    logic exp_stall;
    exp_stall = exp_taken && (exp_target != fs_pc);
    issue(inst, pc);
    i_fs_to_ds_valid = 1'b1;
    i_fs_inst        = NOP;
    i_fs_pc          = fs_pc;
    wait_valid();
    check_bit("o_br_taken", o_br_taken, exp_taken);
    if (exp_taken) check_data("o_br_target", o_br_target, exp_target);
    check_bit("o_br_stall", o_br_stall, exp_stall);
    tick();
    i_fs_to_ds_valid = 1'b0;
    settle();
    check_bit("o_ds_to_es_valid behind branch", o_ds_to_es_valid, !exp_stall);
    if (!exp_stall) check_data("o_pc behind branch", o_pc, fs_pc);
  endtask

  task automatic branch_redirect();
    rv_decode_pkg::xdata_t t;
    run_branch(b_type(13'h010, 5'd1, 5'd1, 3'b000), 64'h1000, 64'h1004, 1'b1, 64'h1010);
    run_branch(b_type(13'h010, 5'd2, 5'd1, 3'b000), 64'h1100, 64'h1104, 1'b0, 64'h0);
    // x10 has bit 63 clear and x8 has it set, so unsigned x10 is below x8
    run_branch(b_type(13'h1ff0, 5'd8, 5'd10, 3'b110), 64'h1200, 64'h11f0,
               1'b1, 64'h11f0);
    run_branch(j_type(21'h000800, 5'd11), 64'h2000, 64'h2004, 1'b1, 64'h2800);
    t = (model[5] + sext12(12'hff8)) & ~64'h1;
    run_branch(i_type(12'hff8, 5'd5, 3'b000, 5'd12, 7'b1100111), 64'h3000, 64'h3004, 1'b1, t);
  endtask

  task automatic invalid_opcode();
    issue(32'h00000073, 64'h4000);  // ecall in the system opcode
    wait_valid();
    check_bit("o_invalid", o_invalid, 1'b1);
    check_bit("o_gpr_wen", o_gpr_wen, 1'b0);
    check_bit("o_mem_ren", o_mem_ren, 1'b0);
    check_bit("o_mem_wen", o_mem_wen, 1'b0);
  endtask

  initial begin
    i_rst_n          = 1'b0;
    i_fs_to_ds_valid = 1'b0;
    i_fs_inst        = NOP;
    i_fs_pc          = '0;
    i_es_allowin     = 1'b1;
    i_es_rd          = '0;
    i_ms_rd          = '0;
    i_ws_rd          = '0;
    i_rf_wen         = 1'b0;
    i_rf_waddr       = '0;
    i_rf_wdata       = '0;
    repeat (RST_CYCLES) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    reset_values();
    decode_and_operands();
    hazard_interlock();
    backpressure_hold();
    branch_redirect();
    invalid_opcode();
    $display("test passed");
    $finish;
  end

endmodule

// File: flist.f
hw/rv_decode_pkg.sv
hw/ds_pipe_ctrl.sv
hw/inst_decoder.sv
hw/gpr_file.sv
hw/branch_unit.sv
hw/id_stage.sv
testbench/id_stage_assertions.sv
testbench/tb_id_stage.sv

// File: Makefile
TOP := tb_id_stage
OBJ := obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)
